/* verilog/mdecPkg.sv */
// Shared types and constants for the MDEC coefficient front end
// Quant tables hold 7-bit entries, four packed per 28-bit word
// Block numbers are 3 bits wide, so at most 8 blocks per macroblock

package mdecPkg;

	// --------------------
	// Stream codes
	localparam logic [15:0] EOB_CODE = 16'hFE00;

	// --------------------
	// Quant table word layout
	localparam int QUANT_PER_WORD = 4;
	localparam int QUANT_WIDTH    = 7;

	// Decoded coefficient headed for dequantization
	typedef struct packed {
		logic              write;
		logic signed [9:0] level;
		logic [5:0]        scale;
		logic              isDC;
		logic [5:0]        linearIdx;
		logic [5:0]        zagIdx;
		logic [2:0]        blockNum;
		logic              matrixComplete;
	} coefInfo_t;

	// Dequantized coefficient headed for the block store
	typedef struct packed {
		logic               write;
		logic [5:0]         idx;
		logic [2:0]         blockNum;
		logic signed [11:0] value;
		logic               matrixComplete;
	} coefWrite_t;

	// One quant table load word
	typedef struct packed {
		logic                                  write;
		logic [QUANT_PER_WORD*QUANT_WIDTH-1:0] value;
		logic [3:0]                            adr;
		logic                                  tblSelect;
	} quantLoad_t;

endpackage

/* verilog/zigzagRom.sv */
// Zigzag scan position to row-major index of an 8x8 block
// Pure lookup, combinational

module zigzagRom (
	input  logic [5:0] i_zagPos,
	output logic [5:0] o_linearIdx
);

	always_comb
	begin
		case (i_zagPos)
			6'd0:  o_linearIdx = 6'd0;
			6'd1:  o_linearIdx = 6'd1;
			6'd2:  o_linearIdx = 6'd8;
			6'd3:  o_linearIdx = 6'd16;
			6'd4:  o_linearIdx = 6'd9;
			6'd5:  o_linearIdx = 6'd2;
			6'd6:  o_linearIdx = 6'd3;
			6'd7:  o_linearIdx = 6'd10;
			6'd8:  o_linearIdx = 6'd17;
			6'd9:  o_linearIdx = 6'd24;
			6'd10: o_linearIdx = 6'd32;
			6'd11: o_linearIdx = 6'd25;
			6'd12: o_linearIdx = 6'd18;
			6'd13: o_linearIdx = 6'd11;
			6'd14: o_linearIdx = 6'd4;
			6'd15: o_linearIdx = 6'd5;
			6'd16: o_linearIdx = 6'd12;
			6'd17: o_linearIdx = 6'd19;
			6'd18: o_linearIdx = 6'd26;
			6'd19: o_linearIdx = 6'd33;
			6'd20: o_linearIdx = 6'd40;
			6'd21: o_linearIdx = 6'd48;
			6'd22: o_linearIdx = 6'd41;
			6'd23: o_linearIdx = 6'd34;
			6'd24: o_linearIdx = 6'd27;
			6'd25: o_linearIdx = 6'd20;
			6'd26: o_linearIdx = 6'd13;
			6'd27: o_linearIdx = 6'd6;
			6'd28: o_linearIdx = 6'd7;
			6'd29: o_linearIdx = 6'd14;
			6'd30: o_linearIdx = 6'd21;
			6'd31: o_linearIdx = 6'd28;
			6'd32: o_linearIdx = 6'd35;
			6'd33: o_linearIdx = 6'd42;
			6'd34: o_linearIdx = 6'd49;
			6'd35: o_linearIdx = 6'd56;
			6'd36: o_linearIdx = 6'd57;
			6'd37: o_linearIdx = 6'd50;
			6'd38: o_linearIdx = 6'd43;
			6'd39: o_linearIdx = 6'd36;
			6'd40: o_linearIdx = 6'd29;
			6'd41: o_linearIdx = 6'd22;
			6'd42: o_linearIdx = 6'd15;
			6'd43: o_linearIdx = 6'd23;
			6'd44: o_linearIdx = 6'd30;
			6'd45: o_linearIdx = 6'd37;
			6'd46: o_linearIdx = 6'd44;
			6'd47: o_linearIdx = 6'd51;
			6'd48: o_linearIdx = 6'd58;
			6'd49: o_linearIdx = 6'd59;
			6'd50: o_linearIdx = 6'd52;
			6'd51: o_linearIdx = 6'd45;
			6'd52: o_linearIdx = 6'd38;
			6'd53: o_linearIdx = 6'd31;
			6'd54: o_linearIdx = 6'd39;
			6'd55: o_linearIdx = 6'd46;
			6'd56: o_linearIdx = 6'd53;
			6'd57: o_linearIdx = 6'd60;
			6'd58: o_linearIdx = 6'd61;
			6'd59: o_linearIdx = 6'd54;
			6'd60: o_linearIdx = 6'd47;
			6'd61: o_linearIdx = 6'd55;
			6'd62: o_linearIdx = 6'd62;
			default: o_linearIdx = 6'd63;
		endcase
	end

endmodule

/* verilog/rleDecoder.sv */
// Run-length decoder for 16-bit halfword coefficient streams
// No handshake, every strobe is consumed in the cycle it arrives
// An end-of-block word seen while waiting for a header is taken as padding
// A run past position 63 raises a sticky error and closes the block

module rleDecoder #(
	parameter int NUM_BLOCKS = 6
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_halfValid,
	input  logic [15:0]        i_halfWord,
	output logic [5:0]         o_zagPos,
	input  logic [5:0]         i_linearIdx,
	output mdecPkg::coefInfo_t o_coef,
	output logic               o_streamError
);
	import mdecPkg::*;

	typedef enum logic {
		stateHeader,
		stateBody
	} rleState_t;

	rleState_t         state;
	logic [5:0]        scale;
	logic [5:0]        zagPos;
	logic [2:0]        blockNum;
	logic [2:0]        nextBlockNum;

	logic [5:0]        wordTop;
	logic signed [9:0] wordLevel;
	logic [6:0]        nextPos;
	logic              isEob;
	logic              runOverflow;
	logic              isLast;
	logic              hdrWord;
	logic              bodyWord;
	logic              closeBlock;

	// --------------------
	// Halfword fields
	// Top 6 bits are scale in a header, zero run in a body word
	assign wordTop   = i_halfWord[15:10];
	assign wordLevel = i_halfWord[9:0];
	assign isEob     = (i_halfWord == EOB_CODE);

	// Next zigzag slot, one extra bit to catch a run past 63
	assign nextPos     = {1'b0, zagPos} + {1'b0, wordTop} + 7'd1;
	assign runOverflow = nextPos[6] & ~isEob;
	assign isLast      = (nextPos == 7'd63) & ~isEob;

	// Events for this strobe
	assign hdrWord    = i_halfValid & (state == stateHeader) & ~isEob;
	assign bodyWord   = i_halfValid & (state == stateBody) & ~isEob & ~runOverflow;
	assign closeBlock = i_halfValid & (state == stateBody) & (isEob | runOverflow | isLast);

	// Block counter wraps at the macroblock size
	assign nextBlockNum = (blockNum == 3'(NUM_BLOCKS - 1)) ? 3'd0 : blockNum + 3'd1;

	// Position to the zigzag ROM, DC always sits at 0
	assign o_zagPos = (state == stateHeader) ? 6'd0 : nextPos[5:0];

	// --------------------
	// FSM and record register
	always_ff @(posedge i_clk)
	begin
		// Payload follows the input every cycle, strobes qualify it
		o_coef.level     <= wordLevel;
		o_coef.scale     <= (state == stateHeader) ? wordTop : scale;
		o_coef.isDC      <= (state == stateHeader);
		o_coef.linearIdx <= i_linearIdx;
		o_coef.zagIdx    <= o_zagPos;
		o_coef.blockNum  <= blockNum;
		if (hdrWord)
		begin
			scale <= wordTop;
		end

		if (i_reset)
		begin
			state                 <= stateHeader;
			zagPos                <= 6'd0;
			blockNum              <= 3'd0;
			o_streamError         <= 1'b0;
			o_coef.write          <= 1'b0;
			o_coef.matrixComplete <= 1'b0;
		end
		else
		begin
			o_coef.write          <= hdrWord | bodyWord;
			o_coef.matrixComplete <= closeBlock;

			if (hdrWord)
			begin
				state  <= stateBody;
				zagPos <= 6'd0;
			end
			else if (closeBlock)
			begin
				state <= stateHeader;
			end
			else if (bodyWord)
			begin
				zagPos <= nextPos[5:0];
			end

			// Block number moves on once the done record has left
			if (closeBlock)
			begin
				blockNum <= nextBlockNum;
			end

			// Sticky until reset
			if (i_halfValid && state == stateBody && runOverflow)
			begin
				o_streamError <= 1'b1;
			end
		end
	end

	// Zigzag position only climbs while inside one block
	posMonotonic: assert property (@(posedge i_clk) disable iff (i_reset)
		(state == stateBody && $past(state) == stateBody) |-> (zagPos >= $past(zagPos)));

endmodule

/* verilog/computeCoef.sv */
// Dequantizer, level x scale x quant / 8, saturated to 12 bits signed
// Fixed 2-cycle latency, no stall, one record per cycle
// Quant table is in zigzag order, luma for blocks 0-1, chroma for 2-5
// Full block mode uses scale 16 and bypasses the table
// A table read in the same cycle as its write sees the old word

module computeCoef (
	input  logic                i_clk,
	input  logic                i_reset,
	input  mdecPkg::coefInfo_t  i_coef,
	input  logic                i_fullBlockType,
	input  mdecPkg::quantLoad_t i_quantLoad,
	output mdecPkg::coefWrite_t o_result
);
	import mdecPkg::*;

	localparam int QUANT_WORD_BITS = QUANT_PER_WORD * QUANT_WIDTH;

	// Stage 0 signals
	logic [5:0]                 scaleSel;
	logic signed [6:0]          signedScale;
	logic signed [15:0]         multF;
	logic                       tableSel;
	logic [4:0]                 quantReadAdr;
	logic [QUANT_WORD_BITS-1:0] quantTbl [0:31];

	// Stage 0 registers
	logic                       pWrite;
	logic                       pMatrixComplete;
	logic                       pFullBlkType;
	logic [5:0]                 pIndex;
	logic [2:0]                 pBlk;
	logic [1:0]                 pEntrySel;
	logic signed [15:0]         pMultF;
	logic [QUANT_WORD_BITS-1:0] pQuantWord;

	// Stage 1 signals
	logic [QUANT_WIDTH-1:0]     quantEntry;
	logic signed [QUANT_WIDTH:0] quantMul;
	logic signed [23:0]         outCalc;
	logic signed [23:0]         outRound;
	logic signed [20:0]         outDiv;
	logic signed [11:0]         clipped;

	// Stage 1 registers
	logic                       ppWrite;
	logic                       ppMatrixComplete;
	logic [5:0]                 ppIndex;
	logic [2:0]                 ppBlk;
	logic signed [11:0]         ppValue;

	// Output rounding
	logic                       allOnes;
	logic [11:0]                biased;

	// --------------------
	// Stage 0
	// DC uses 8, full mode 16 for every term
	assign scaleSel    = i_fullBlockType ? 6'd16 : (i_coef.isDC ? 6'd8 : i_coef.scale);
	assign signedScale = {1'b0, scaleSel};
	assign multF       = i_coef.level * signedScale;

	// Chroma table for blocks 2..5, word holds four zigzag slots
	assign tableSel     = i_coef.blockNum[1] | i_coef.blockNum[2];
	assign quantReadAdr = {tableSel, i_coef.zagIdx[5:2]};

	always_ff @(posedge i_clk)
	begin
		pIndex       <= i_coef.linearIdx;
		pBlk         <= i_coef.blockNum;
		pFullBlkType <= i_fullBlockType;
		pMultF       <= multF;
		pEntrySel    <= i_coef.zagIdx[1:0];
		if (i_reset)
		begin
			pWrite          <= 1'b0;
			pMatrixComplete <= 1'b0;
		end
		else
		begin
			pWrite          <= i_coef.write;
			pMatrixComplete <= i_coef.matrixComplete;
		end
	end

	// Table RAM, registered read so the read returns the pre-write word
	always_ff @(posedge i_clk)
	begin
		if (i_quantLoad.write)
		begin
			quantTbl[{i_quantLoad.tblSelect, i_quantLoad.adr}] <= i_quantLoad.value;
		end
		pQuantWord <= quantTbl[quantReadAdr];
	end

	// --------------------
	// Stage 1
	assign quantEntry = pQuantWord[int'(pEntrySel) * QUANT_WIDTH +: QUANT_WIDTH];
	assign quantMul   = pFullBlkType ? 8'sd1 : $signed({1'b0, quantEntry});
	assign outCalc    = pMultF * quantMul;

	// Negative values get +7 so the shift truncates toward zero
	assign outRound = outCalc + (outCalc[23] ? 24'sd7 : 24'sd0);
	assign outDiv   = outRound[23:3];

	// Clamp to -2048..2047
	always_comb
	begin
		if (outDiv > 21'sd2047)
		begin
			clipped = 12'sd2047;
		end
		else if (outDiv < -21'sd2048)
		begin
			clipped = -12'sd2048;
		end
		else
		begin
			clipped = outDiv[11:0];
		end
	end

	always_ff @(posedge i_clk)
	begin
		ppIndex <= pIndex;
		ppBlk   <= pBlk;
		ppValue <= clipped;
		if (i_reset)
		begin
			ppWrite          <= 1'b0;
			ppMatrixComplete <= 1'b0;
		end
		else
		begin
			ppWrite          <= pWrite;
			ppMatrixComplete <= pMatrixComplete;
		end
	end

	// --------------------
	// Output, even toward zero, -1 kept as is
	assign allOnes = &ppValue;
	assign biased  = ppValue + {11'd0, ppValue[11] & ~allOnes};

	always_comb
	begin
		o_result.write          = ppWrite;
		o_result.idx            = ppIndex;
		o_result.blockNum       = ppBlk;
		o_result.value          = {biased[11:1], allOnes};
		o_result.matrixComplete = ppMatrixComplete;
	end

	// Each coefficient comes out exactly two cycles after it went in
	latencyTwo: assert property (@(posedge i_clk) disable iff (i_reset)
		i_coef.write |-> ##2 o_result.write);

endmodule

/* verilog/coefBlockStore.sv */
// Holds one 8x8 block of dequantized coefficients
// Positions never written in the current block read as zero
// The block stays readable until the first write of the next block
// No back-pressure, the source must wait until the block is read

module coefBlockStore (
	input  logic                i_clk,
	input  logic                i_reset,
	input  mdecPkg::coefWrite_t i_write,
	input  logic [5:0]          i_readIdx,
	output logic signed [11:0]  o_readValue,
	output logic                o_blockDone,
	output logic [2:0]          o_doneBlockNum
);

	logic signed [11:0] coefMem [0:63];
	logic [63:0]        writtenMask;
	logic [63:0]        idxBit;
	logic [63:0]        maskBase;
	logic               newBlock;

	// --------------------
	// Mask update
	assign idxBit = 64'd1 << i_write.idx;

	// First write of a block starts from an empty mask
	assign maskBase = newBlock ? 64'd0 : writtenMask;

	always_ff @(posedge i_clk)
	begin
		if (i_write.write)
		begin
			coefMem[i_write.idx] <= i_write.value;
		end
		if (i_write.matrixComplete)
		begin
			o_doneBlockNum <= i_write.blockNum;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			writtenMask <= 64'd0;
			newBlock    <= 1'b1;
			o_blockDone <= 1'b0;
		end
		else
		begin
			o_blockDone <= i_write.matrixComplete;
			if (i_write.write)
			begin
				writtenMask <= maskBase | idxBit;
				newBlock    <= 1'b0;
			end
			// Done record may also carry the last write
			if (i_write.matrixComplete)
			begin
				newBlock <= 1'b1;
			end
		end
	end

	// --------------------
	// Read port
	assign o_readValue = writtenMask[i_readIdx] ? coefMem[i_readIdx] : 12'sd0;

	// Zigzag mapping must never hit the same slot twice in a block
	noDoubleWrite: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_write.write && !newBlock) |-> !writtenMask[i_write.idx]);

endmodule

/* verilog/mdecCoefTop.sv */
// Coefficient front end, RLE decode, zigzag, dequantize, block store
// Halfword to block-done latency is 4 cycles
// Next block must not start until the current one has been read out

module mdecCoefTop #(
	parameter int NUM_BLOCKS = 6
) (
	input  logic               i_clk,
	input  logic               i_reset,
	input  logic               i_halfValid,
	input  logic [15:0]        i_halfWord,
	input  logic               i_fullBlockType,
	input  logic               i_quantWrt,
	input  logic [27:0]        i_quantValue,
	input  logic [3:0]         i_quantAdr,
	input  logic               i_quantTblSelect,
	input  logic [5:0]         i_readIdx,
	output logic signed [11:0] o_readValue,
	output logic               o_blockDone,
	output logic [2:0]         o_doneBlockNum,
	output logic               o_streamError
);
	import mdecPkg::*;

	coefInfo_t  coefInfo;
	coefWrite_t coefResult;
	quantLoad_t quantLoad;
	logic [5:0] zagPos;
	logic [5:0] linearIdx;

	// Table load bundle
	assign quantLoad = '{
		write:     i_quantWrt,
		value:     i_quantValue,
		adr:       i_quantAdr,
		tblSelect: i_quantTblSelect
	};

	rleDecoder #(.NUM_BLOCKS(NUM_BLOCKS)) decoder (.i_clk(i_clk), .i_reset(i_reset),
		.i_halfValid(i_halfValid), .i_halfWord(i_halfWord), .o_zagPos(zagPos),
		.i_linearIdx(linearIdx), .o_coef(coefInfo), .o_streamError(o_streamError));

	// Index comes back into the same decoder record
	zigzagRom zigzag (.i_zagPos(zagPos), .o_linearIdx(linearIdx));

	computeCoef dequant (.i_clk(i_clk), .i_reset(i_reset), .i_coef(coefInfo),
		.i_fullBlockType(i_fullBlockType), .i_quantLoad(quantLoad), .o_result(coefResult));

	coefBlockStore store (.i_clk(i_clk), .i_reset(i_reset), .i_write(coefResult),
		.i_readIdx(i_readIdx), .o_readValue(o_readValue), .o_blockDone(o_blockDone),
		.o_doneBlockNum(o_doneBlockNum));

endmodule

/* tests/mdecCoefTb.sv */
// Testbench for the MDEC coefficient front end
// Runs the command file tests/coefStreamInput.txt from the project root
// Stops at the first mismatch, the run limit scales with the command count
// Commands that feed halfwords must be followed by a W before reading

module mdecCoefTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD     = 40;
	localparam int RESET_CYCLES   = 8;
	localparam int CYCLES_PER_CMD = 80;
	localparam string STIM_FILE   = "tests/coefStreamInput.txt";

	logic               clk;
	logic               reset;
	logic               halfValid;
	logic [15:0]        halfWord;
	logic               fullBlockType;
	logic               quantWrt;
	logic [27:0]        quantValue;
	logic [3:0]         quantAdr;
	logic               quantTblSelect;
	logic [5:0]         readIdx;
	logic signed [11:0] readValue;
	logic               blockDone;
	logic [2:0]         doneBlockNum;
	logic               streamError;

	// Parsed commands, one entry per file line
	logic [7:0] cmdQ [$];
	int         argA [$];
	int         argB [$];
	int         argC [$];

	int cycleCount = 0;
	int cycleLimit = 0;

	mdecCoefTop #(.NUM_BLOCKS(6)) UUT (.i_clk(clk), .i_reset(reset),
		.i_halfValid(halfValid), .i_halfWord(halfWord), .i_fullBlockType(fullBlockType),
		.i_quantWrt(quantWrt), .i_quantValue(quantValue), .i_quantAdr(quantAdr),
		.i_quantTblSelect(quantTblSelect), .i_readIdx(readIdx), .o_readValue(readValue),
		.o_blockDone(blockDone), .o_doneBlockNum(doneBlockNum), .o_streamError(streamError));

	// --------------------
	// Clock and run limit
	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			abortRun($sformatf("Timeout after %0d cycles, the DUT stopped responding",
				cycleCount));
		end
	end

	// --------------------
	// Helpers
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic signed [31:0] actual,
		input logic signed [31:0] expected);
		if (actual !== expected)
		begin
			abortRun($sformatf("[FAIL] %0t %s: got %0d, expected %0d", $time, name,
				actual, expected));
		end
	endtask

	// Reads the whole file up front so the run limit is known
	task automatic loadCommands();
		int               fd;
		int               n;
		int               a;
		int               b;
		int               c;
		logic [63:0]      tok;
		logic [8*256-1:0] restOfLine;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			abortRun("Could not open the stimulus file");
		end
		while (!$feof(fd))
		begin
			tok = '0;
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
			begin
				break;
			end
			a = 0;
			b = 0;
			c = 0;
			case (tok[7:0])
				"#": n = $fgets(restOfLine, fd);
				"Q": n = $fscanf(fd, "%d %d %h", a, b, c);
				"H": n = $fscanf(fd, "%h", a);
				"R": n = $fscanf(fd, "%d %d", a, b);
				"F", "W", "E": n = $fscanf(fd, "%d", a);
				default: abortRun("Unknown command in the stimulus file");
			endcase
			// Comment lines carry no command
			if (tok[7:0] != "#")
			begin
				cmdQ.push_back(tok[7:0]);
				argA.push_back(a);
				argB.push_back(b);
				argC.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// One command, started on a falling edge
	task automatic runCommand(input int i);
		int a;
		int b;
		int c;
		a = argA[i];
		b = argB[i];
		c = argC[i];
		@(negedge clk);
		// Strobes last a single cycle
		halfValid = 1'b0;
		quantWrt  = 1'b0;
		case (cmdQ[i])
			"Q":
			begin
				quantWrt       = 1'b1;
				quantTblSelect = a[0];
				quantAdr       = b[3:0];
				quantValue     = c[27:0];
			end
			"F": fullBlockType = a[0];
			"H":
			begin
				halfValid = 1'b1;
				halfWord  = a[15:0];
			end
			"W":
			begin
				while (!blockDone)
				begin
					@(negedge clk);
				end
				checkValue("o_doneBlockNum", 32'(doneBlockNum), a);
				// Done is a single-cycle pulse
				@(negedge clk);
				checkValue("o_blockDone", 32'(blockDone), 0);
			end
			"R":
			begin
				readIdx = a[5:0];
				// Read port is combinational, sample mid-cycle
				#(CLK_PERIOD / 4);
				checkValue("o_readValue", 32'(readValue), b);
			end
			"E": checkValue("o_streamError", 32'(streamError), a);
			default: abortRun("Unexpected command code");
		endcase
	endtask

	// --------------------
	// Main sequence
	initial
	begin
		reset          = 1'b1;
		halfValid      = 1'b0;
		halfWord       = 16'd0;
		fullBlockType  = 1'b0;
		quantWrt       = 1'b0;
		quantValue     = 28'd0;
		quantAdr       = 4'd0;
		quantTblSelect = 1'b0;
		readIdx        = 6'd0;

		loadCommands();
		cycleLimit = (cmdQ.size() + RESET_CYCLES) * CYCLES_PER_CMD;

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < cmdQ.size(); i++)
		begin
			runCommand(i);
		end

		@(negedge clk);
		$display("Regression passed");
		$finish;
	end

endmodule

/* sources.f */
verilog/mdecPkg.sv
verilog/zigzagRom.sv
verilog/rleDecoder.sv
verilog/computeCoef.sv
verilog/coefBlockStore.sv
verilog/mdecCoefTop.sv
tests/mdecCoefTb.sv

/* Makefile */
TOP = mdecCoefTb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* tests/coefStreamInput.txt */
# Q tbl adr word(hex) | F fullMode | H halfword(hex) | W blockNum
# R index expected(decimal) | E streamError
Q 0 0 1C30510
Q 0 1 5078C05
Q 1 0 1A2C491
Q 1 15 C6C8F14
F 0
E 0
H 1005
H 0003
H 07F9
H FE00
W 0
R 0 80
R 1 14
R 8 0
R 16 -48
H FDFF
H 0200
H FE00
W 1
R 0 2046
R 1 -2048
R 16 0
H 1005
H 0003
H 07F9
H FE00
W 2
R 0 84
R 1 12
R 16 -44
F 1
H 179C
H 0025
H 03FD
H FE00
W 3
F 0
R 0 -200
R 1 74
R 8 -6
H 0801
H F80A
W 4
R 0 16
R 8 0
R 63 246
E 0
H 0C02
H 0004
H FC01
W 5
E 1
R 0 34
R 1 12
R 63 0
H 0400
H 03FF
H 0BFF
H 03FD
H FE00
W 0
R 1 -1
R 9 0
R 2 -8
E 1
